// File: Makefile
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "test incomplete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
    input  logic                       clk,
    input  logic                       reset,
    fdIf.decode                        fd,
    mwIf.decode                        mw,
    hazIf.user                         haz,
    deIf.decode                        de,
    input  logic [rvPkg::regAddrW-1:0] dbgRegAddr,
    output logic [rvPkg::xlen-1:0]     dbgRegData
);
    import rvPkg::*;

    logic [xlen-1:0]     regs [32];
    opcodeE              opcode;
    logic [2:0]          funct3;
    ctrlT                ctrlD;
    logic [xlen-1:0]     immD;
    logic [xlen-1:0]     rd1D;
    logic [xlen-1:0]     rd2D;
    logic [regAddrW-1:0] rs1D;
    logic [regAddrW-1:0] rs2D;
    logic [regAddrW-1:0] rdD;

    assign opcode = opcodeE'(fd.instr[6:0]);
    assign funct3 = fd.instr[14:12];
    assign rs1D   = fd.instr[19:15];
    assign rs2D   = fd.instr[24:20];
    assign rdD    = fd.instr[11:7];

    always_comb begin
        ctrlD = '0;  // unknown or invalid stays a bubble
        immD  = '0;
        if (fd.valid) begin
            case (opcode)
                opReg: begin
                    ctrlD.regWrite = 1'b1;
                    case (funct3)
                        3'b000:  ctrlD.aluOp = fd.instr[30] ? aluSub : aluAdd;
                        3'b111:  ctrlD.aluOp = aluAnd;
                        3'b110:  ctrlD.aluOp = aluOr;
                        default: ctrlD.regWrite = 1'b0;
                    endcase
                end
                opImm: begin
                    if (funct3 == 3'b000) begin  // addi only
                        ctrlD.regWrite  = 1'b1;
                        ctrlD.aluSrcImm = 1'b1;
                    end
                    immD = {{20{fd.instr[31]}}, fd.instr[31:20]};
                end
                opLoad: begin
                    if (funct3 == 3'b010) begin
                        ctrlD.regWrite  = 1'b1;
                        ctrlD.memToReg  = 1'b1;
                        ctrlD.aluSrcImm = 1'b1;
                    end
                    immD = {{20{fd.instr[31]}}, fd.instr[31:20]};
                end
                opStore: begin
                    if (funct3 == 3'b010) begin
                        ctrlD.memWrite  = 1'b1;
                        ctrlD.aluSrcImm = 1'b1;
                    end
                    immD = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
                end
                opBranch: begin
                    if (funct3 == 3'b000) begin  // beq
                        ctrlD.branch = 1'b1;
                    end
                    immD = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
                            fd.instr[30:25], fd.instr[11:8], 1'b0};
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mw.regWrite && mw.rd != '0) begin
            regs[mw.rd] <= mw.result;
        end
    end

    // x0 reads zero and a same-cycle write is seen immediately
    function automatic logic [xlen-1:0] readReg(input logic [regAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (mw.regWrite && mw.rd == addr) begin
            return mw.result;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rd1D       = readReg(rs1D);
        rd2D       = readReg(rs2D);
        dbgRegData = readReg(dbgRegAddr);
    end

    assign haz.rs1D = rs1D;
    assign haz.rs2D = rs2D;

    // decode/execute register
    always_ff @(posedge clk) begin
        if (reset || haz.flushE) begin
            de.ctrl <= '0;
        end else begin
            de.ctrl <= ctrlD;
        end
    end

    always_ff @(posedge clk) begin
        de.rd1 <= rd1D;
        de.rd2 <= rd2D;
        de.imm <= immD;
        de.pc  <= fd.pc;
        de.rs1 <= rs1D;
        de.rs2 <= rs2D;
        de.rd  <= rdD;
    end

endmodule

// File: executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic                   clk,
    input  logic                   reset,
    deIf.execute                   de,
    hazIf.user                     haz,
    input  logic [rvPkg::xlen-1:0] aluResultM,
    input  logic [rvPkg::xlen-1:0] resultW,
    emIf.execute                   em,
    output logic [rvPkg::xlen-1:0] branchTarget
);
    import rvPkg::*;

    logic [xlen-1:0] srcA;
    logic [xlen-1:0] opB;  // forwarded rs2, also the store data
    logic [xlen-1:0] srcB;
    logic [xlen-1:0] aluOut;

    function automatic logic [xlen-1:0] fwdMux(
        input fwdSelE          sel,
        input logic [xlen-1:0] regVal,
        input logic [xlen-1:0] memVal,
        input logic [xlen-1:0] wbVal
    );
        case (sel)
            fwdMem:  return memVal;
            fwdWb:   return wbVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA = fwdMux(haz.fwdA, de.rd1, aluResultM, resultW);
    assign opB  = fwdMux(haz.fwdB, de.rd2, aluResultM, resultW);
    assign srcB = de.ctrl.aluSrcImm ? de.imm : opB;

    always_comb begin
        case (de.ctrl.aluOp)
            aluSub:  aluOut = srcA - srcB;
            aluAnd:  aluOut = srcA & srcB;
            aluOr:   aluOut = srcA | srcB;
            default: aluOut = srcA + srcB;
        endcase
    end

    // beq resolved here
    assign haz.branchTakenE = de.ctrl.branch && (srcA == opB);
    assign branchTarget     = de.pc + de.imm;

    assign haz.rs1E      = de.rs1;
    assign haz.rs2E      = de.rs2;
    assign haz.rdE       = de.rd;
    assign haz.memToRegE = de.ctrl.memToReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            em.regWrite <= 1'b0;
            em.memWrite <= 1'b0;
            em.memToReg <= 1'b0;
        end else begin
            em.regWrite <= de.ctrl.regWrite;
            em.memWrite <= de.ctrl.memWrite;
            em.memToReg <= de.ctrl.memToReg;
        end
    end

    always_ff @(posedge clk) begin
        em.aluResult <= aluOut;
        em.storeData <= opB;
        em.rd        <= de.rd;
    end

endmodule

// File: fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   run,
    input  logic                   imemWrite,
    input  logic [5:0]             imemAddr,
    input  logic [rvPkg::xlen-1:0] imemData,
    hazIf.user                     haz,
    input  logic [rvPkg::xlen-1:0] branchTarget,
    output logic [rvPkg::xlen-1:0] pc,
    fdIf.fetch                     fd
);
    import rvPkg::*;

    logic [xlen-1:0] imem [imemDepth];
    logic [xlen-1:0] instrF;

    always_ff @(posedge clk) begin
        if (imemWrite) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instrF = imem[pc[7:2]];  // word indexed

    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pc <= '0;
        end else if (haz.branchTakenE) begin
            pc <= branchTarget;
        end else if (!haz.stallF) begin
            pc <= pc + 32'd4;
        end
    end

    // fetch/decode register
    always_ff @(posedge clk) begin
        if (reset || !run || haz.flushD) begin
            fd.valid <= 1'b0;  // bubble into decode
        end else if (!haz.stallD) begin
            fd.valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!haz.stallD) begin
            fd.instr <= instrF;
            fd.pc    <= pc;
        end
    end

endmodule

// File: hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
    hazIf.hazard haz
);
    import rvPkg::*;

    logic lwStall;

    // memory stage wins over writeback, x0 never forwarded
    function automatic fwdSelE pickFwd(
        input logic [regAddrW-1:0] rs,
        input logic [regAddrW-1:0] rdM,
        input logic                regWriteM,
        input logic [regAddrW-1:0] rdW,
        input logic                regWriteW
    );
        if (rs == '0) begin
            return fwdNone;
        end
        if (regWriteM && rdM == rs) begin
            return fwdMem;
        end
        if (regWriteW && rdW == rs) begin
            return fwdWb;
        end
        return fwdNone;
    endfunction

    assign haz.fwdA = pickFwd(haz.rs1E, haz.rdM, haz.regWriteM, haz.rdW, haz.regWriteW);
    assign haz.fwdB = pickFwd(haz.rs2E, haz.rdM, haz.regWriteM, haz.rdW, haz.regWriteW);

    // load in execute feeding the instruction in decode
    assign lwStall = haz.memToRegE && haz.rdE != '0
                     && (haz.rdE == haz.rs1D || haz.rdE == haz.rs2D);

    assign haz.stallF = lwStall;
    assign haz.stallD = lwStall;

    // taken branch kills the two younger instructions
    assign haz.flushD = haz.branchTakenE;
    assign haz.flushE = lwStall || haz.branchTakenE;  // bubble either way

endmodule

// File: memoryStage.sv
`timescale 1ns/10ps

module memoryStage (
    input  logic                   clk,
    input  logic                   reset,
    emIf.memory                    em,
    hazIf.user                     haz,
    output logic [rvPkg::xlen-1:0] aluResultM,
    mwIf.memory                    mw
);
    import rvPkg::*;

    logic [xlen-1:0]                dmem [dmemDepth];
    logic [$clog2(dmemDepth)-1:0]   wordAddr;
    logic [xlen-1:0]                loadData;

    assign wordAddr = em.aluResult[$clog2(dmemDepth)+1:2];

    always_ff @(posedge clk) begin
        if (em.memWrite) begin
            dmem[wordAddr] <= em.storeData;
        end
    end

    assign loadData   = dmem[wordAddr];  // async read
    assign aluResultM = em.aluResult;

    assign haz.rdM       = em.rd;
    assign haz.regWriteM = em.regWrite;

    // memory/writeback register with the result mux in front
    always_ff @(posedge clk) begin
        if (reset) begin
            mw.regWrite <= 1'b0;
        end else begin
            mw.regWrite <= em.regWrite;
        end
    end

    always_ff @(posedge clk) begin
        mw.result <= em.memToReg ? loadData : em.aluResult;
        mw.rd     <= em.rd;
    end

    assign haz.rdW       = mw.rd;
    assign haz.regWriteW = mw.regWrite;

endmodule

// File: rvCoreTb.sv
`timescale 1ns/10ps

module rvCoreTb;
    import rvPkg::*;

    localparam logic [6:0]  immOpc  = 7'b0010011;
    localparam logic [6:0]  loadOpc = 7'b0000011;
    localparam logic [31:0] nopWord = 32'h0000_0013;  // addi x0,x0,0

    logic                clk;
    logic                reset;
    logic                run;
    logic                imemWrite;
    logic [5:0]          imemAddr;
    logic [xlen-1:0]     imemData;
    logic [regAddrW-1:0] dbgRegAddr;
    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     dbgRegData;

    logic [31:0] progWords [$];
    string       testName;
    int          testErrors;
    int          passCount;
    int          failCount;

    rvCoreTop i_rvCoreTop (
        .clk        (clk),
        .reset      (reset),
        .run        (run),
        .imemWrite  (imemWrite),
        .imemAddr   (imemAddr),
        .imemData   (imemData),
        .dbgRegAddr (dbgRegAddr),
        .pc         (pc),
        .dbgRegData (dbgRegData)
    );

    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [31:0] rFormat(input logic [6:0] funct7, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] iFormat(input logic [6:0] opc, input logic [2:0] funct3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, funct3, rd, opc};
    endfunction

    // sw only with funct3 fixed to word
    function automatic logic [31:0] sFormat(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // beq only with bit 0 of the byte offset dropped
    function automatic logic [31:0] bFormat(input logic [4:0] rs1, input logic [4:0] rs2,
                                            input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [xlen-1:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [11:0] randImm();
        logic [31:0] r;
        r = $urandom();
        return r[11:0];
    endfunction

    function automatic logic [xlen-1:0] lastPc();
        return (progWords.size() - 1) * 4;  // the spin beq
    endfunction

    task automatic resetCore();
        @(posedge clk);
        #2;
        reset = 1'b1;
        run   = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
    endtask

    // whole memory rewritten and the tail filled with nops
    task automatic loadProgram();
        resetCore();
        for (int i = 0; i < imemDepth; i++) begin
            imemWrite = 1'b1;
            imemAddr  = i[5:0];
            imemData  = (i < progWords.size()) ? progWords[i] : nopWord;
            @(posedge clk);
            #2;
        end
        imemWrite = 1'b0;
    endtask

    task automatic runUntil(input logic [xlen-1:0] endAddr);
        int cycles;
        cycles = 0;
        run    = 1'b1;
        @(negedge clk);
        while (pc != endAddr && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (pc != endAddr) begin
            $display("%s: pc never reached end address %h, last pc %h", testName, endAddr, pc);
            testErrors++;
        end
        repeat (6) @(posedge clk);  // older instructions drain to writeback
    endtask

    task automatic checkReg(input logic [regAddrW-1:0] idx, input logic [xlen-1:0] expected);
        @(posedge clk);
        #2;
        dbgRegAddr = idx;
        @(negedge clk);
        if (dbgRegData !== expected) begin
            $display("mismatch %s x%0d: expected %h actual %h",
                     testName, idx, expected, dbgRegData);
            testErrors++;
        end
    endtask

    task automatic startTest(input string name);
        testName   = name;
        testErrors = 0;
        progWords.delete();
    endtask

    task automatic finishTest();
        if (testErrors == 0) begin
            passCount++;
            $display("%s: ok", testName);
        end else begin
            failCount++;
            $display("%s: %0d errors", testName, testErrors);
        end
    endtask

    // no operand reaches execute before its producer has written back
    task automatic independentArith();
        logic [11:0]     immA;
        logic [11:0]     immB;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        startTest("independent arith");
        immA = randImm();
        immB = randImm();
        a    = sext12(immA);
        b    = sext12(immB);
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd1, 5'd0, immA));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd2, 5'd0, immB));
        repeat (3) progWords.push_back(nopWord);
        progWords.push_back(rFormat(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));  // add
        progWords.push_back(rFormat(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));  // sub
        progWords.push_back(rFormat(7'h00, 3'b111, 5'd8, 5'd1, 5'd2));  // and
        progWords.push_back(rFormat(7'h00, 3'b110, 5'd9, 5'd1, 5'd2));  // or
        progWords.push_back(bFormat(5'd0, 5'd0, 13'd0));
        loadProgram();
        runUntil(lastPc());
        checkReg(5'd1, a);
        checkReg(5'd2, b);
        checkReg(5'd3, a + b);
        checkReg(5'd4, a - b);
        checkReg(5'd8, a & b);
        checkReg(5'd9, a | b);
        finishTest();
    endtask

    task automatic forwardChain();
        logic [11:0]     immC;
        logic [11:0]     immP;
        logic [xlen-1:0] c;
        startTest("forward chain");
        immC = randImm();
        immP = randImm();
        c    = sext12(immC);
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd1, 5'd0, immC));
        progWords.push_back(rFormat(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));  // x1 from memory
        progWords.push_back(rFormat(7'h20, 3'b000, 5'd3, 5'd2, 5'd1));  // x2 mem, x1 wb
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd10, 5'd0, immP));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd10, 5'd0, ~immP));
        // both stages hold x10 and the younger value must win
        progWords.push_back(rFormat(7'h00, 3'b000, 5'd11, 5'd10, 5'd0));
        progWords.push_back(bFormat(5'd0, 5'd0, 13'd0));
        loadProgram();
        runUntil(lastPc());
        checkReg(5'd2, c + c);
        checkReg(5'd3, c);
        checkReg(5'd11, sext12(~immP));
        finishTest();
    endtask

    task automatic loadUse();
        logic [11:0]     immV;
        logic [xlen-1:0] v;
        startTest("load use");
        immV = randImm();
        v    = sext12(immV);
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd4, 5'd0, immV));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd13, 5'd0, 12'h040));  // base
        progWords.push_back(sFormat(5'd4, 5'd13, 12'd8));
        progWords.push_back(iFormat(loadOpc, 3'b010, 5'd5, 5'd13, 12'd8));
        progWords.push_back(rFormat(7'h00, 3'b000, 5'd6, 5'd5, 5'd5));   // needs the stall
        progWords.push_back(rFormat(7'h20, 3'b000, 5'd16, 5'd6, 5'd5));
        progWords.push_back(bFormat(5'd0, 5'd0, 13'd0));
        loadProgram();
        runUntil(lastPc());
        checkReg(5'd5, v);
        checkReg(5'd6, v + v);
        checkReg(5'd16, v);
        finishTest();
    endtask

    task automatic takenBranch();
        logic [11:0]     immR;
        logic [xlen-1:0] r;
        startTest("taken branch");
        immR = randImm();
        r    = sext12(immR);
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd7, 5'd0, immR));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd17, 5'd0, immR));
        progWords.push_back(bFormat(5'd7, 5'd17, 13'd12));  // operands forwarded
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd7, 5'd0, ~immR));  // skipped
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd7, 5'd7, 12'd1));   // skipped
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd18, 5'd0, 12'h055));
        progWords.push_back(bFormat(5'd0, 5'd0, 13'd0));
        loadProgram();
        runUntil(lastPc());
        checkReg(5'd7, r);
        checkReg(5'd17, r);
        checkReg(5'd18, 32'h0000_0055);
        finishTest();
    endtask

    task automatic notTakenBranch();
        startTest("not taken branch");
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd19, 5'd0, 12'd3));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd20, 5'd0, 12'd4));
        progWords.push_back(bFormat(5'd19, 5'd20, 13'd8));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd21, 5'd0, 12'd9));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd0, 5'd0, 12'h123));
        progWords.push_back(rFormat(7'h00, 3'b000, 5'd22, 5'd0, 5'd0));   // x0 in memory
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd0, 5'd0, 12'h456));
        progWords.push_back(iFormat(immOpc, 3'b000, 5'd24, 5'd0, 12'd5));  // no x0 write here
        progWords.push_back(rFormat(7'h00, 3'b000, 5'd23, 5'd0, 5'd21));  // x0 in writeback
        progWords.push_back(bFormat(5'd0, 5'd0, 13'd0));
        loadProgram();
        runUntil(lastPc());
        checkReg(5'd0, '0);
        checkReg(5'd19, 32'd3);
        checkReg(5'd20, 32'd4);
        checkReg(5'd21, 32'd9);
        checkReg(5'd22, '0);
        checkReg(5'd23, 32'd9);
        checkReg(5'd24, 32'd5);
        finishTest();
    endtask

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        imemWrite  = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        dbgRegAddr = '0;
        passCount  = 0;
        failCount  = 0;
        void'($urandom(32'h261d7fe2));
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        independentArith();
        forwardChain();
        loadUse();
        takenBranch();
        notTakenBranch();

        $display("tests ok: %0d, tests with errors: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: rvCoreTop.sv
`timescale 1ns/10ps

module rvCoreTop (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       run,
    input  logic                       imemWrite,
    input  logic [5:0]                 imemAddr,
    input  logic [rvPkg::xlen-1:0]     imemData,
    input  logic [rvPkg::regAddrW-1:0] dbgRegAddr,
    output logic [rvPkg::xlen-1:0]     pc,
    output logic [rvPkg::xlen-1:0]     dbgRegData
);
    import rvPkg::*;

    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] aluResultM;

    fdIf  fdBus ();
    deIf  deBus ();
    emIf  emBus ();
    mwIf  mwBus ();
    hazIf hazBus ();

    fetchStage i_fetchStage (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .imemWrite    (imemWrite),
        .imemAddr     (imemAddr),
        .imemData     (imemData),
        .haz          (hazBus.user),
        .branchTarget (branchTarget),
        .pc           (pc),
        .fd           (fdBus.fetch)
    );

    decodeStage i_decodeStage (
        .clk        (clk),
        .reset      (reset),
        .fd         (fdBus.decode),
        .mw         (mwBus.decode),
        .haz        (hazBus.user),
        .de         (deBus.decode),
        .dbgRegAddr (dbgRegAddr),
        .dbgRegData (dbgRegData)
    );

    hazardUnit i_hazardUnit (
        .haz (hazBus.hazard)
    );

    executeStage i_executeStage (
        .clk          (clk),
        .reset        (reset),
        .de           (deBus.execute),
        .haz          (hazBus.user),
        .aluResultM   (aluResultM),
        .resultW      (mwBus.result),  // writeback value
        .em           (emBus.execute),
        .branchTarget (branchTarget)
    );

    memoryStage i_memoryStage (
        .clk        (clk),
        .reset      (reset),
        .em         (emBus.memory),
        .haz        (hazBus.user),
        .aluResultM (aluResultM),
        .mw         (mwBus.memory)
    );

endmodule

// File: rvPkg.sv
package rvPkg;

    localparam int xlen      = 32;
    localparam int regAddrW  = 5;
    localparam int imemDepth = 64;  // words, indexed by pc[7:2]
    localparam int dmemDepth = 64;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOpE;

    // operand source in execute
    typedef enum logic [1:0] {
        fwdNone = 2'b00,
        fwdWb   = 2'b01,
        fwdMem  = 2'b10
    } fwdSelE;

    // all zero is a bubble
    typedef struct packed {
        logic  regWrite;
        logic  memWrite;
        logic  memToReg;
        logic  branch;
        logic  aluSrcImm;
        aluOpE aluOp;
    } ctrlT;

endpackage

// File: sim.f
rvPkg.sv
stageIf.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
rvCoreTop.sv
rvCoreTb.sv

// File: stageIf.sv
`timescale 1ns/10ps

interface fdIf;
    import rvPkg::*;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic            valid;
    modport fetch  (output instr, pc, valid);
    modport decode (input instr, pc, valid);
endinterface

interface deIf;
    import rvPkg::*;
    ctrlT                ctrl;
    logic [xlen-1:0]     rd1;
    logic [xlen-1:0]     rd2;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     pc;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
    modport decode  (output ctrl, rd1, rd2, imm, pc, rs1, rs2, rd);
    modport execute (input ctrl, rd1, rd2, imm, pc, rs1, rs2, rd);
endinterface

interface emIf;
    import rvPkg::*;
    logic                regWrite;
    logic                memWrite;
    logic                memToReg;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     storeData;
    logic [regAddrW-1:0] rd;
    modport execute (output regWrite, memWrite, memToReg, aluResult, storeData, rd);
    modport memory  (input regWrite, memWrite, memToReg, aluResult, storeData, rd);
endinterface

interface mwIf;
    import rvPkg::*;
    logic                regWrite;
    logic [xlen-1:0]     result;
    logic [regAddrW-1:0] rd;
    modport memory (output regWrite, result, rd);
    modport decode (input regWrite, result, rd);
endinterface

interface hazIf;
    import rvPkg::*;
    logic [regAddrW-1:0] rs1D;
    logic [regAddrW-1:0] rs2D;
    logic [regAddrW-1:0] rs1E;
    logic [regAddrW-1:0] rs2E;
    logic [regAddrW-1:0] rdE;
    logic [regAddrW-1:0] rdM;
    logic [regAddrW-1:0] rdW;
    logic                memToRegE;
    logic                regWriteM;
    logic                regWriteW;
    logic                branchTakenE;
    fwdSelE              fwdA;
    fwdSelE              fwdB;
    logic                stallF;
    logic                stallD;
    logic                flushD;
    logic                flushE;
    modport hazard (
        input  rs1D, rs2D, rs1E, rs2E, rdE, memToRegE, rdM, regWriteM, rdW, regWriteW,
        input  branchTakenE,
        output fwdA, fwdB, stallF, stallD, flushD, flushE
    );
    modport user (
        output rs1D, rs2D, rs1E, rs2E, rdE, memToRegE, rdM, regWriteM, rdW, regWriteW,
        output branchTakenE,
        input  fwdA, fwdB, stallF, stallD, flushD, flushE
    );
endinterface
